// ==== logic/sensor_pkg.sv ====
package sensor_pkg;

  typedef logic [7:0] byte_t;

  // Kind of bus transaction
  typedef enum logic {
    OP_READ,   // Pointer write, then byte reads
    OP_WRITE   // Pointer write, then one data byte
  } op_e;

  typedef enum logic [2:0] {
    PH_START,
    PH_PROBE,
    PH_CFG_WRITE,
    PH_CFG_READ,
    PH_READING,
    PH_NO_RESPOND
  } phase_e;

  // Engine steps for one request
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_PTR,
    ST_DATA,
    ST_NBYTES,
    ST_RX,
    ST_WAIT_DONE
  } step_e;

  // Sensor register pointers
  localparam byte_t REG_TEMP      = 8'd0;
  localparam byte_t REG_CFG_WRITE = 8'd9;
  localparam byte_t REG_CFG_READ  = 8'd3;

endpackage

// ==== logic/sensor_txn_if.sv ====
interface sensor_txn_if
  import sensor_pkg::*;
();

  logic  req;    // Held until done or nak
  op_e   op;
  byte_t ptr;
  byte_t wdata;
  logic  done;   // One-cycle pulse
  logic  nak;    // One-cycle pulse
  byte_t rdata;  // Last byte read, held

  modport seq (
    output req,
    output op,
    output ptr,
    output wdata,
    input  done,
    input  nak,
    input  rdata
  );

  modport eng (
    input  req,
    input  op,
    input  ptr,
    input  wdata,
    output done,
    output nak,
    output rdata
  );

endinterface

// ==== logic/retry_counter.sv ====
module retry_counter #(
  parameter int MAX_RETRIES = 10
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_nak_inc,
  input  logic i_nak_clr,
  input  logic i_cfg_inc,
  input  logic i_cfg_clr,
  output logic o_nak_last,
  output logic o_cfg_last
);

  localparam int CW = $clog2(MAX_RETRIES + 1);

  logic [1:0] inc;
  logic [1:0] clr;
  logic [1:0] last;

  // Index 0 counts NAKs, index 1 counts readback mismatches
  assign inc = {i_cfg_inc, i_nak_inc};
  assign clr = {i_cfg_clr, i_nak_clr};

  for (genvar g = 0; g < 2; g++) begin : g_cnt
    logic [CW-1:0] r_cnt;

    always_ff @(posedge i_clk or posedge i_rst) begin
      if (i_rst) begin
        r_cnt <= '0;
      end else if (clr[g]) begin
        r_cnt <= '0;
      end else if (inc[g] && (r_cnt != CW'(MAX_RETRIES))) begin
        r_cnt <= r_cnt + 1'b1;  // Saturates at the limit
      end
    end

    // Next increment would hit the limit
    assign last[g] = (r_cnt >= CW'(MAX_RETRIES - 1));
  end

  assign o_nak_last = last[0];
  assign o_cfg_last = last[1];

endmodule

// ==== logic/sensor_phase_fsm.sv ====
module sensor_phase_fsm
  import sensor_pkg::*;
#(
  parameter byte_t CFG_VALUE = 8'd4
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_nak_last,
  input  logic      i_cfg_last,
  output logic      o_nak_inc,
  output logic      o_nak_clr,
  output logic      o_cfg_inc,
  output logic      o_cfg_clr,
  output logic      o_sample_valid,
  output logic      o_no_respond,
  sensor_txn_if.seq txn
);

  phase_e r_phase;
  logic   r_req;
  logic   r_sample_valid;
  logic   active;
  logic   cfg_match;

  assign active    = (r_phase != PH_START) && (r_phase != PH_NO_RESPOND);
  assign cfg_match = (txn.rdata == CFG_VALUE);

  // Request contents follow the phase
  always_comb begin
    case (r_phase)
      PH_CFG_WRITE: begin
        txn.op  = OP_WRITE;
        txn.ptr = REG_CFG_WRITE;
      end
      PH_CFG_READ: begin
        txn.op  = OP_READ;
        txn.ptr = REG_CFG_READ;
      end
      default: begin
        txn.op  = OP_READ;
        txn.ptr = REG_TEMP;  // Probe and continuous reads
      end
    endcase
  end

  assign txn.wdata = CFG_VALUE;
  assign txn.req   = r_req;

  // Counter strobes
  assign o_nak_clr = txn.done;
  assign o_nak_inc = txn.nak && !i_nak_last;
  assign o_cfg_clr = txn.done && (r_phase == PH_CFG_READ) && cfg_match;
  assign o_cfg_inc = txn.done && (r_phase == PH_CFG_READ) && !cfg_match && !i_cfg_last;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_phase        <= PH_START;
      r_req          <= 1'b0;
      r_sample_valid <= 1'b0;
    end else begin
      r_sample_valid <= txn.done && (r_phase == PH_READING);

      // Drop after the answer, raise again one idle cycle later
      if (txn.done || txn.nak) begin
        r_req <= 1'b0;
      end else if (active && !r_req) begin
        r_req <= 1'b1;
      end

      case (r_phase)
        PH_START: begin
          r_phase <= PH_PROBE;
        end
        PH_NO_RESPOND: begin
          r_phase <= PH_NO_RESPOND;  // Absorbing
        end
        default: begin
          if (txn.nak) begin
            if (i_nak_last) begin
              r_phase <= PH_NO_RESPOND;
            end
          end else if (txn.done) begin
            case (r_phase)
              PH_PROBE:     r_phase <= PH_CFG_WRITE;
              PH_CFG_WRITE: r_phase <= PH_CFG_READ;
              PH_CFG_READ: begin
                if (cfg_match) begin
                  r_phase <= PH_READING;
                end else if (i_cfg_last) begin
                  r_phase <= PH_NO_RESPOND;
                end else begin
                  r_phase <= PH_CFG_WRITE;  // Write it again
                end
              end
              default:      r_phase <= r_phase;
            endcase
          end
        end
      endcase
    end
  end

  assign o_sample_valid = r_sample_valid;
  assign o_no_respond   = (r_phase == PH_NO_RESPOND);

endmodule

// ==== logic/i2c_txn_engine.sv ====
module i2c_txn_engine
  import sensor_pkg::*;
#(
  parameter logic [6:0] SLAVE_ADDR = 7'd39,
  parameter byte_t      NBYTES     = 8'd0
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_addr_ready,
  input  logic      i_nbytes_ready,
  input  logic      i_wr_ready,
  input  byte_t     i_rd_bits,
  input  logic      i_rd_valid,
  input  logic      i_nak,
  output logic      o_start,
  output byte_t     o_addr_bits,
  output logic      o_addr_valid,
  output byte_t     o_nbytes_bits,
  output logic      o_nbytes_valid,
  output byte_t     o_wr_bits,
  output logic      o_wr_valid,
  output logic      o_rd_ready,
  sensor_txn_if.eng txn
);

  localparam byte_t ADDR_WR = {SLAVE_ADDR, 1'b0};
  localparam byte_t ADDR_RD = {SLAVE_ADDR, 1'b1};

  step_e r_step;
  logic  r_nak_q;
  byte_t r_rx_left;  // Bytes still expected after the current one
  logic  nak_rise;
  logic  accept;
  logic  addr_fire;
  logic  nb_fire;
  logic  wr_fire;
  logic  rd_fire;
  logic  rx_last;

  assign nak_rise  = i_nak && !r_nak_q;
  // Skip the cycle of our own answer, req is still high there
  assign accept    = (r_step == ST_IDLE) && txn.req && !txn.done && !txn.nak;
  assign addr_fire = o_addr_valid && i_addr_ready;
  assign nb_fire   = o_nbytes_valid && i_nbytes_ready;
  assign wr_fire   = o_wr_valid && i_wr_ready;
  assign rd_fire   = (r_step == ST_RX) && o_rd_ready && i_rd_valid;
  assign rx_last   = (r_rx_left == '0);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      r_step         <= ST_IDLE;
      r_nak_q        <= 1'b0;
      o_start        <= 1'b0;
      o_addr_valid   <= 1'b0;
      o_nbytes_valid <= 1'b0;
      o_wr_valid     <= 1'b0;
      o_rd_ready     <= 1'b0;
      txn.done       <= 1'b0;
      txn.nak        <= 1'b0;
    end else begin
      r_nak_q  <= i_nak;
      o_start  <= 1'b0;
      txn.done <= 1'b0;
      txn.nak  <= 1'b0;

      // Valid drops once its beat is taken
      if (addr_fire) begin
        o_addr_valid <= 1'b0;
      end
      if (nb_fire) begin
        o_nbytes_valid <= 1'b0;
      end
      if (wr_fire) begin
        o_wr_valid <= 1'b0;
      end

      case (r_step)
        ST_IDLE: begin
          if (accept) begin
            r_step       <= ST_ADDR;
            o_start      <= 1'b1;
            o_addr_valid <= 1'b1;
          end
        end
        ST_ADDR: begin
          if (addr_fire) begin
            r_step     <= ST_PTR;
            o_wr_valid <= 1'b1;
          end
        end
        ST_PTR: begin
          if (wr_fire) begin
            if (txn.op == OP_WRITE) begin
              r_step     <= ST_DATA;
              o_wr_valid <= 1'b1;
            end else begin
              r_step         <= ST_NBYTES;
              o_addr_valid   <= 1'b1;  // Read address with the count
              o_nbytes_valid <= 1'b1;
              o_rd_ready     <= 1'b1;
            end
          end
        end
        ST_DATA: begin
          if (wr_fire) begin
            r_step <= ST_WAIT_DONE;
          end
        end
        ST_NBYTES: begin
          if (nb_fire) begin
            r_step <= ST_RX;
          end
        end
        ST_RX: begin
          if (rd_fire && rx_last) begin
            r_step     <= ST_WAIT_DONE;
            o_rd_ready <= 1'b0;
          end
        end
        ST_WAIT_DONE: begin
          if (i_addr_ready && !i_nak) begin  // Master back to idle
            r_step   <= ST_IDLE;
            txn.done <= 1'b1;
          end
        end
        default: r_step <= ST_IDLE;
      endcase

      // Abort on a new NAK
      if (nak_rise && (r_step != ST_IDLE)) begin
        r_step         <= ST_IDLE;
        o_start        <= 1'b0;
        o_addr_valid   <= 1'b0;
        o_nbytes_valid <= 1'b0;
        o_wr_valid     <= 1'b0;
        o_rd_ready     <= 1'b0;
        txn.done       <= 1'b0;
        txn.nak        <= 1'b1;
      end
    end
  end

  // Beat payloads
  always_ff @(posedge i_clk) begin
    case (r_step)
      ST_IDLE: begin
        if (accept) begin
          o_addr_bits <= ADDR_WR;
        end
      end
      ST_ADDR: begin
        if (addr_fire) begin
          o_wr_bits <= txn.ptr;
        end
      end
      ST_PTR: begin
        if (wr_fire) begin
          if (txn.op == OP_WRITE) begin
            o_wr_bits <= txn.wdata;
          end else begin
            o_addr_bits   <= ADDR_RD;
            o_nbytes_bits <= NBYTES;
            r_rx_left     <= NBYTES;
          end
        end
      end
      ST_RX: begin
        if (rd_fire) begin
          txn.rdata <= i_rd_bits;
          r_rx_left <= r_rx_left - 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/sensor_ctrl_top.sv ====
module sensor_ctrl_top
  import sensor_pkg::*;
#(
  parameter logic [6:0] SLAVE_ADDR  = 7'd39,
  parameter byte_t      NBYTES      = 8'd0,
  parameter byte_t      CFG_VALUE   = 8'd4,
  parameter int         MAX_RETRIES = 10
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_addr_ready,
  input  logic  i_nbytes_ready,
  input  logic  i_wr_ready,
  input  byte_t i_rd_bits,
  input  logic  i_rd_valid,
  input  logic  i_nak,
  output logic  o_start,
  output byte_t o_addr_bits,
  output logic  o_addr_valid,
  output byte_t o_nbytes_bits,
  output logic  o_nbytes_valid,
  output byte_t o_wr_bits,
  output logic  o_wr_valid,
  output logic  o_rd_ready,
  output byte_t o_sample_bits,
  output logic  o_sample_valid,
  output logic  o_no_respond
);

  logic nak_inc;
  logic nak_clr;
  logic cfg_inc;
  logic cfg_clr;
  logic nak_last;
  logic cfg_last;

  sensor_txn_if txn_bus ();

  sensor_phase_fsm #(
    .CFG_VALUE (CFG_VALUE)
  ) u_phase_fsm (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_nak_last     (nak_last),
    .i_cfg_last     (cfg_last),
    .o_nak_inc      (nak_inc),
    .o_nak_clr      (nak_clr),
    .o_cfg_inc      (cfg_inc),
    .o_cfg_clr      (cfg_clr),
    .o_sample_valid (o_sample_valid),
    .o_no_respond   (o_no_respond),
    .txn            (txn_bus.seq)
  );

  retry_counter #(
    .MAX_RETRIES (MAX_RETRIES)
  ) u_retry (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_nak_inc  (nak_inc),
    .i_nak_clr  (nak_clr),
    .i_cfg_inc  (cfg_inc),
    .i_cfg_clr  (cfg_clr),
    .o_nak_last (nak_last),
    .o_cfg_last (cfg_last)
  );

  i2c_txn_engine #(
    .SLAVE_ADDR (SLAVE_ADDR),
    .NBYTES     (NBYTES)
  ) u_engine (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_addr_ready   (i_addr_ready),
    .i_nbytes_ready (i_nbytes_ready),
    .i_wr_ready     (i_wr_ready),
    .i_rd_bits      (i_rd_bits),
    .i_rd_valid     (i_rd_valid),
    .i_nak          (i_nak),
    .o_start        (o_start),
    .o_addr_bits    (o_addr_bits),
    .o_addr_valid   (o_addr_valid),
    .o_nbytes_bits  (o_nbytes_bits),
    .o_nbytes_valid (o_nbytes_valid),
    .o_wr_bits      (o_wr_bits),
    .o_wr_valid     (o_wr_valid),
    .o_rd_ready     (o_rd_ready),
    .txn            (txn_bus.eng)
  );

  assign o_sample_bits = txn_bus.rdata;  // Held by the engine

endmodule

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter realtime PERIOD = 100ns
) (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
  end

  always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== verification/sensor_ctrl_sva.sv ====
module sensor_ctrl_sva
  import sensor_pkg::*;
(
  input logic  i_clk,
  input logic  i_rst,
  input logic  i_addr_ready,
  input logic  i_nbytes_ready,
  input logic  i_wr_ready,
  input logic  i_nak,
  input logic  o_start,
  input byte_t o_addr_bits,
  input logic  o_addr_valid,
  input byte_t o_nbytes_bits,
  input logic  o_nbytes_valid,
  input byte_t o_wr_bits,
  input logic  o_wr_valid,
  input logic  o_sample_valid,
  input logic  o_no_respond
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  a_start_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_start |-> o_addr_valid ##1 !o_start)
    else begin
      fail_count++;
      $error("o_start longer than one cycle or without o_addr_valid");
    end

  // A NAK abort is the only legal way to withdraw a beat
  a_addr_hold: assert property (@(posedge i_clk) disable iff (i_rst || i_nak)
    o_addr_valid && !i_addr_ready |=> o_addr_valid && $stable(o_addr_bits))
    else begin
      fail_count++;
      $error("address beat withdrawn or changed before transfer");
    end

  a_nbytes_hold: assert property (@(posedge i_clk) disable iff (i_rst || i_nak)
    o_nbytes_valid && !i_nbytes_ready |=> o_nbytes_valid && $stable(o_nbytes_bits))
    else begin
      fail_count++;
      $error("count beat withdrawn or changed before transfer");
    end

  a_wr_hold: assert property (@(posedge i_clk) disable iff (i_rst || i_nak)
    o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_bits))
    else begin
      fail_count++;
      $error("write beat withdrawn or changed before transfer");
    end

  a_halt_sticky: assert property (@(posedge i_clk) disable iff (i_rst)
    o_no_respond |=> o_no_respond)
    else begin
      fail_count++;
      $error("o_no_respond fell outside reset");
    end

  a_no_sample_halted: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_sample_valid && o_no_respond))
    else begin
      fail_count++;
      $error("sample published while halted");
    end

endmodule

// ==== verification/tb_sensor_ctrl.sv ====
module tb_sensor_ctrl
  import sensor_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam byte_t ADDR_WR   = 8'd78;  // Device 39 with write bit
  localparam byte_t ADDR_RD   = 8'd79;
  localparam byte_t NBYTES    = 8'd0;
  localparam byte_t CFG_VALUE = 8'd4;
  localparam int    NROWS     = 24;
  localparam int    LIMIT     = NROWS * 60 + 20;

  typedef struct {
    logic  rst;         // Reset before this row
    op_e   op;
    byte_t ptr;
    logic  nak;
    logic  force_en;    // Wrong readback wanted
    byte_t force_byte;
    byte_t sensor;
    logic  exp_sample;
    logic  exp_halt;
  } row_t;

  logic  i_clk;
  logic  i_rst;
  logic  i_addr_ready;
  logic  i_nbytes_ready;
  logic  i_wr_ready;
  byte_t i_rd_bits;
  logic  i_rd_valid;
  logic  i_nak;
  logic  o_start;
  byte_t o_addr_bits;
  logic  o_addr_valid;
  byte_t o_nbytes_bits;
  logic  o_nbytes_valid;
  byte_t o_wr_bits;
  logic  o_wr_valid;
  logic  o_rd_ready;
  byte_t o_sample_bits;
  logic  o_sample_valid;
  logic  o_no_respond;

  row_t        rows [NROWS];
  row_t        cur;
  logic [15:0] lfsr = 16'd21591;
  int          cycles;

  // Sensor and master model state
  int    cnt_addr;
  int    cnt_nb;
  int    cnt_wr;
  int    cnt_rd;
  int    n_addr;
  int    n_wr;
  int    nak_hold;
  byte_t addr_log [2];
  byte_t wr_log [2];
  byte_t nb_log;
  byte_t cfg_store;
  logic  finishing;
  logic  pending_rx;
  logic  aborted;
  logic  txn_ended;
  int    start_count;
  int    sample_count;
  byte_t last_sample;

  tb_clk_gen u_clk (.o_clk(i_clk));

  sensor_ctrl_top #(.MAX_RETRIES(3)) u_dut (.*);

  bind sensor_ctrl_top sensor_ctrl_sva u_sva (.*);

  function automatic logic [15:0] step_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = step_lfsr(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // One-cycle strobe after a random wait while the channel wants it
  task automatic pace(input logic want, input logic cur_rdy, inout int cnt, output logic nxt);
    nxt = 1'b0;
    if (cur_rdy || !want) begin
      cnt = -1;
    end else begin
      if (cnt < 0) cnt = random_bits(2);
      if (cnt == 0) nxt = 1'b1;
      else cnt--;
    end
  endtask

  task automatic check(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_row(input int i, input logic rst, input op_e op, input byte_t ptr,
                         input logic nak, input logic fe, input byte_t fb, input byte_t sensor,
                         input logic smp, input logic halt);
    rows[i] = '{rst, op, ptr, nak, fe, fb, sensor, smp, halt};
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout: the DUT stopped answering before all rows were applied");
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  always @(posedge i_clk) begin : model
    logic nxt;
    if (i_rst) begin
      n_addr = 0;
      n_wr = 0;
      nak_hold = 0;
      cnt_addr = -1;
      cnt_nb = -1;
      cnt_wr = -1;
      cnt_rd = -1;
      finishing = 0;
      pending_rx = 0;
      aborted = 0;
      cfg_store = 8'h00;
      i_addr_ready <= 1'b0;
      i_nbytes_ready <= 1'b0;
      i_wr_ready <= 1'b0;
      i_rd_valid <= 1'b0;
      i_nak <= 1'b0;
    end else begin
      if (o_start) begin
        n_addr = 0;
        n_wr = 0;
        finishing = 0;
        pending_rx = 0;
        aborted = 0;
        start_count++;
      end
      if (o_sample_valid) begin
        sample_count++;
        last_sample = o_sample_bits;
      end
      if (nak_hold > 0) begin
        nak_hold--;
        if (nak_hold == 0) i_nak <= 1'b0;
      end
      if (i_addr_ready && o_addr_valid && n_addr < 2) begin
        addr_log[n_addr] = o_addr_bits;
        n_addr++;
      end
      if (i_addr_ready && finishing && !aborted) begin  // Master idle again
        finishing = 0;
        txn_ended = 1;
      end
      if (i_nbytes_ready && o_nbytes_valid && !aborted) begin
        nb_log = o_nbytes_bits;
        pending_rx = 1;
      end
      if (i_wr_ready && o_wr_valid && !aborted && n_wr < 2) begin
        wr_log[n_wr] = o_wr_bits;
        n_wr++;
        if (n_wr == 1 && cur.nak) begin
          i_nak <= 1'b1;
          nak_hold = 2;
          aborted = 1;
          txn_ended = 1;
        end else if (n_wr == 2) begin
          if (wr_log[0] == REG_CFG_WRITE) cfg_store = wr_log[1];
          finishing = 1;
        end
      end
      if (i_rd_valid && o_rd_ready && !aborted) begin
        pending_rx = 0;
        finishing = 1;
      end
      pace(o_addr_valid || finishing, i_addr_ready, cnt_addr, nxt);
      i_addr_ready <= nxt;
      pace(o_nbytes_valid, i_nbytes_ready, cnt_nb, nxt);
      i_nbytes_ready <= nxt;
      pace(o_wr_valid, i_wr_ready, cnt_wr, nxt);
      i_wr_ready <= nxt;
      pace(pending_rx && o_rd_ready && !aborted, i_rd_valid, cnt_rd, nxt);
      i_rd_valid <= nxt;
      if (nxt) begin
        if (wr_log[0] == REG_CFG_READ) i_rd_bits <= cur.force_en ? cur.force_byte : cfg_store;
        else i_rd_bits <= cur.sensor;
      end
    end
  end

  initial begin
    int starts_seen;
    int samples_before;
    add_row(0,  0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h11, 0, 0);
    add_row(1,  0, OP_READ,  REG_TEMP,      0, 0, 8'h00, 8'h11, 0, 0);
    add_row(2,  0, OP_WRITE, REG_CFG_WRITE, 0, 0, 8'h00, 8'h11, 0, 0);
    add_row(3,  0, OP_READ,  REG_CFG_READ,  1, 0, 8'h00, 8'h11, 0, 0);
    add_row(4,  0, OP_READ,  REG_CFG_READ,  0, 1, 8'h55, 8'h11, 0, 0);
    add_row(5,  0, OP_WRITE, REG_CFG_WRITE, 0, 0, 8'h00, 8'h11, 0, 0);
    add_row(6,  0, OP_READ,  REG_CFG_READ,  0, 0, 8'h00, 8'h11, 0, 0);
    add_row(7,  0, OP_READ,  REG_TEMP,      0, 0, 8'h00, 8'hA1, 1, 0);
    add_row(8,  0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h22, 0, 0);
    add_row(9,  0, OP_READ,  REG_TEMP,      0, 0, 8'h00, 8'h3C, 1, 0);
    add_row(10, 0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h33, 0, 0);
    add_row(11, 0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h44, 0, 0);
    add_row(12, 0, OP_READ,  REG_TEMP,      0, 0, 8'h00, 8'h7E, 1, 0);
    add_row(13, 0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h55, 0, 0);
    add_row(14, 0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h66, 0, 0);
    add_row(15, 0, OP_READ,  REG_TEMP,      1, 0, 8'h00, 8'h77, 0, 1);
    add_row(16, 1, OP_READ,  REG_TEMP,      0, 0, 8'h00, 8'h11, 0, 0);
    add_row(17, 0, OP_WRITE, REG_CFG_WRITE, 1, 0, 8'h00, 8'h11, 0, 0);
    add_row(18, 0, OP_WRITE, REG_CFG_WRITE, 0, 0, 8'h00, 8'h11, 0, 0);
    add_row(19, 0, OP_READ,  REG_CFG_READ,  0, 1, 8'h00, 8'h11, 0, 0);
    add_row(20, 0, OP_WRITE, REG_CFG_WRITE, 0, 0, 8'h00, 8'h11, 0, 0);
    add_row(21, 0, OP_READ,  REG_CFG_READ,  0, 1, 8'hFF, 8'h11, 0, 0);
    add_row(22, 0, OP_WRITE, REG_CFG_WRITE, 0, 0, 8'h00, 8'h11, 0, 0);
    add_row(23, 0, OP_READ,  REG_CFG_READ,  0, 1, 8'h05, 8'h11, 0, 1);

    i_rst = 1'b1;
    i_addr_ready = 1'b0;
    i_nbytes_ready = 1'b0;
    i_wr_ready = 1'b0;
    i_rd_bits = 8'h00;
    i_rd_valid = 1'b0;
    i_nak = 1'b0;
    cycles = 0;
    start_count = 0;
    sample_count = 0;
    txn_ended = 0;
    wr_log[0] = 8'h00;
    cur = rows[0];
    starts_seen = 0;
    repeat (5) @(posedge i_clk);
    i_rst <= 1'b0;

    for (int r = 0; r < NROWS; r++) begin
      cur = rows[r];
      if (cur.rst) begin
        @(posedge i_clk);
        i_rst <= 1'b1;
        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;
      end
      while (start_count == starts_seen) @(negedge i_clk);
      starts_seen = start_count;
      samples_before = sample_count;
      while (!txn_ended) @(negedge i_clk);
      txn_ended = 0;

      check("o_addr_bits write address", addr_log[0], ADDR_WR);
      check("o_wr_bits pointer", wr_log[0], cur.ptr);
      if (!cur.nak) begin
        if (cur.op == OP_WRITE) begin
          check("address beats", n_addr, 1);
          check("write beats", n_wr, 2);
          check("o_wr_bits data", wr_log[1], CFG_VALUE);
        end else begin
          check("address beats", n_addr, 2);
          check("write beats", n_wr, 1);
          check("o_addr_bits read address", addr_log[1], ADDR_RD);
          check("o_nbytes_bits", nb_log, NBYTES);
        end
      end

      repeat (3) @(negedge i_clk);
      check("o_sample_valid count", sample_count - samples_before, cur.exp_sample);
      if (cur.exp_sample) check("o_sample_bits", last_sample, cur.sensor);
      if (cur.exp_halt) begin
        repeat (10) @(negedge i_clk);
        check("o_no_respond", o_no_respond, 1);
        check("o_start count after halt", start_count, starts_seen);
      end else begin
        check("o_no_respond", o_no_respond, 0);
      end
    end

    if (u_dut.u_sva.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== src.f ====
logic/sensor_pkg.sv
logic/sensor_txn_if.sv
logic/retry_counter.sv
logic/sensor_phase_fsm.sv
logic/i2c_txn_engine.sv
logic/sensor_ctrl_top.sv
verification/tb_clk_gen.sv
verification/sensor_ctrl_sva.sv
verification/tb_sensor_ctrl.sv
